//--- hw/lineAssembler.sv
`timescale 1ns/10ps
//////////////////////////////
// Line assembler.
// Collects received bytes into memory lines
// and counts the bytes stored so far.
//////////////////////////////
module lineAssembler (
    input  logic               clk,
    input  logic               rst,
    input  logic               rxValid,
    input  uartTestPkg::byteT  rxData,
    input  logic               writeDone,
    output logic               writeRequest,
    output uartTestPkg::lineT  writeLine,
    output uartTestPkg::countT bytesReceived
);
    logic [uartTestPkg::ByteIndexWidth-1:0] fillIndex;         // Next free byte slot.
    logic memoryFull;
    logic acceptByte;

    assign memoryFull = (bytesReceived == uartTestPkg::MemoryCapacity);
    assign acceptByte = rxValid && !memoryFull;

    always_ff @(posedge clk) begin
        if (rst) begin
            fillIndex     <= '0;
            writeRequest  <= 1'b0;
            bytesReceived <= '0;
        end else begin
            if (acceptByte) begin
                fillIndex <= fillIndex + 1'b1;
                // Last slot filled, hand the line over.
                if (fillIndex == uartTestPkg::LineSize - 1) writeRequest <= 1'b1;
            end
            if (writeDone) begin
                writeRequest  <= 1'b0;
                bytesReceived <= bytesReceived + uartTestPkg::countT'(uartTestPkg::LineSize);
            end
        end
    end

    // The line is held until writeDone, the next byte is a frame away.
    always_ff @(posedge clk) begin
        if (acceptByte) writeLine.bits[{fillIndex, 3'b000} +: 8] <= rxData;
    end

endmodule

//--- hw/lineMemory.sv
`timescale 1ns/10ps
//////////////////////////////
// Line memory.
// Single port, one line per access,
// done one cycle after each request.
//////////////////////////////
module lineMemory (
    input  logic                 clk,
    input  uartTestPkg::memReqT  memReq,
    output uartTestPkg::memRespT memResp
);
    uartTestPkg::lineT lines [uartTestPkg::LineCount];

    always_ff @(posedge clk) begin
        memResp.done <= memReq.enable;                         // Fixed one-cycle latency.
    end

    always_ff @(posedge clk) begin
        if (memReq.enable) begin
            if (memReq.isWrite) begin
                lines[memReq.addr] <= memReq.writeLine;
            end else begin
                memResp.readLine <= lines[memReq.addr];        // Valid in the done cycle.
            end
        end
    end

endmodule

//--- hw/memoryTestController.sv
`timescale 1ns/10ps
//////////////////////////////
// Memory test controller.
// Fills the memory from the assembler, then
// reads it back byte by byte to the transmitter.
//////////////////////////////
module memoryTestController (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 writeRequest,
    input  uartTestPkg::lineT    writeLine,
    input  uartTestPkg::countT   bytesReceived,
    output logic                 writeDone,
    output uartTestPkg::memReqT  memReq,
    input  uartTestPkg::memRespT memResp,
    input  logic                 txEmpty,
    output logic                 txWrite,
    output uartTestPkg::byteT    txData,
    output logic                 finished
);
    typedef enum logic [1:0] {
        stateReceive,
        stateTransmit,
        stateFinished
    } ctrlStateT;

    ctrlStateT          state;
    uartTestPkg::countT txCount;                               // Bytes handed to the transmitter.

    always_comb begin
        memReq.isWrite   = (state == stateReceive);
        memReq.writeLine = writeLine;
        case (state)
            stateReceive: begin
                // A done cycle closes the access, no second request then.
                memReq.enable = writeRequest && !memResp.done;
                memReq.addr   = bytesReceived[uartTestPkg::ByteIndexWidth +:
                                              uartTestPkg::LineAddrWidth];
            end
            stateTransmit: begin
                memReq.enable = txEmpty && !memResp.done;      // One read per free transmitter.
                memReq.addr   = txCount[uartTestPkg::ByteIndexWidth +: uartTestPkg::LineAddrWidth];
            end
            default: begin
                memReq.enable = 1'b0;
                memReq.addr   = txCount[uartTestPkg::ByteIndexWidth +: uartTestPkg::LineAddrWidth];
            end
        endcase

        writeDone = (state == stateReceive) && memResp.done;
        txWrite   = (state == stateTransmit) && memResp.done;
        txData    = memResp.readLine.bytes[txCount[uartTestPkg::ByteIndexWidth-1:0]];
        finished  = (state == stateFinished);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stateReceive;
            txCount <= '0;
        end else begin
            case (state)
                stateReceive: begin
                    if (bytesReceived == uartTestPkg::MemoryCapacity) state <= stateTransmit;
                end
                stateTransmit: begin
                    if (txWrite) begin
                        txCount <= txCount + 1'b1;
                        if (txCount == uartTestPkg::MemoryCapacity - 1) state <= stateFinished;
                    end
                end
                stateFinished: state <= stateFinished;         // One pass only.
                default:       state <= stateReceive;
            endcase
        end
    end

endmodule

//--- hw/uartMemoryTestUnit.sv
`timescale 1ns/10ps
//////////////////////////////
// UART memory loopback tester, top level.
// Stores 64 received bytes, then echoes them.
//////////////////////////////
module uartMemoryTestUnit (
    input  logic               clk,
    input  logic               rst,
    input  logic               uartRx,
    output logic               uartTx,
    output uartTestPkg::countT bytesReceived,
    output logic               finished
);
    logic                 rxValid;
    uartTestPkg::byteT    rxData;
    logic                 writeRequest;
    logic                 writeDone;
    uartTestPkg::lineT    writeLine;
    uartTestPkg::memReqT  memReq;
    uartTestPkg::memRespT memResp;
    logic                 txEmpty;
    logic                 txWrite;
    uartTestPkg::byteT    txData;

    uartReceiver receiver0 (.clk, .rst, .rx(uartRx), .rxValid, .rxData);

    lineAssembler assembler0 (
        .clk, .rst, .rxValid, .rxData, .writeDone,
        .writeRequest, .writeLine, .bytesReceived
    );

    memoryTestController controller0 (
        .clk, .rst, .writeRequest, .writeLine, .bytesReceived, .writeDone,
        .memReq, .memResp, .txEmpty, .txWrite, .txData, .finished
    );

    lineMemory memory0 (.clk, .memReq, .memResp);

    uartTransmitter transmitter0 (.clk, .rst, .txWrite, .txData, .tx(uartTx), .txEmpty);

endmodule

//--- hw/uartReceiver.sv
`timescale 1ns/10ps
//////////////////////////////
// UART receiver, 8N1.
// Synchronises the line, finds the start edge
// and samples every bit at mid-bit.
//////////////////////////////
module uartReceiver (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx,
    output logic              rxValid,
    output uartTestPkg::byteT rxData
);
    typedef enum logic [1:0] {
        stateIdle,
        stateStart,
        stateData,
        stateStop
    } rxStateT;

    rxStateT state;
    logic    rxMeta;
    logic    rxSync;
    logic    [2:0] bitIndex;
    logic    [$clog2(uartTestPkg::ClocksPerBit)-1:0] bitTimer;
    logic    halfBit;
    logic    fullBit;

    assign halfBit = (bitTimer == uartTestPkg::ClocksPerBit / 2 - 1);
    assign fullBit = (bitTimer == uartTestPkg::ClocksPerBit - 1);

    // Two-flop synchroniser, idles high.
    always_ff @(posedge clk) begin
        if (rst) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= rx;
            rxSync <= rxMeta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= stateIdle;
            bitTimer <= '0;
            bitIndex <= '0;
            rxValid  <= 1'b0;
        end else begin
            rxValid  <= 1'b0;
            bitTimer <= bitTimer + 1'b1;
            case (state)
                stateIdle: begin
                    bitTimer <= '0;
                    if (!rxSync) state <= stateStart;          // Falling start edge.
                end
                stateStart: begin
                    if (halfBit) begin
                        bitTimer <= '0;
                        bitIndex <= '0;
                        // Line went high again, so it was a glitch.
                        state    <= rxSync ? stateIdle : stateData;
                    end
                end
                stateData: begin
                    if (fullBit) begin
                        bitTimer <= '0;
                        bitIndex <= bitIndex + 1'b1;
                        if (bitIndex == 3'd7) state <= stateStop;
                    end
                end
                stateStop: begin
                    if (fullBit) begin
                        rxValid <= rxSync;                     // Low stop bit drops the frame.
                        state   <= stateIdle;
                    end
                end
                default: state <= stateIdle;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top.
    always_ff @(posedge clk) begin
        if (state == stateData && fullBit) rxData <= {rxSync, rxData[7:1]};
    end

endmodule

//--- hw/uartTestPkg.sv
//////////////////////////////
// UART memory loopback tester.
// Shared sizes, the bit timing and the
// memory line and port types.
//////////////////////////////
package uartTestPkg;

    localparam int ClocksPerBit   = 16;                         // Clock cycles per serial bit.
    localparam int LineSize       = 4;                          // Bytes per memory line.
    localparam int MemoryCapacity = 64;                         // Total bytes stored.
    localparam int LineCount      = MemoryCapacity / LineSize;
    localparam int LineAddrWidth  = $clog2(LineCount);
    localparam int ByteIndexWidth = $clog2(LineSize);

    typedef logic [7:0] byteT;

    // Holds 0 up to a full memory.
    typedef logic [$clog2(MemoryCapacity):0] countT;

    // One memory line, seen as raw bits or as bytes.
    typedef union packed {
        logic [LineSize*8-1:0] bits;
        byteT [LineSize-1:0]   bytes;                           // Byte 0 sits in the low bits.
    } lineT;

    typedef struct packed {
        logic                     enable;
        logic                     isWrite;
        logic [LineAddrWidth-1:0] addr;                         // Line address.
        lineT                     writeLine;
    } memReqT;

    typedef struct packed {
        logic done;                                             // One cycle after each request.
        lineT readLine;
    } memRespT;

endpackage

//--- hw/uartTransmitter.sv
`timescale 1ns/10ps
//////////////////////////////
// UART transmitter, 8N1.
// Sends one 10-bit frame per write,
// LSB first, and idles high.
//////////////////////////////
module uartTransmitter (
    input  logic              clk,
    input  logic              rst,
    input  logic              txWrite,
    input  uartTestPkg::byteT txData,
    output logic              tx,
    output logic              txEmpty
);
    logic [9:0] frame;                                         // Stop, data, start.
    logic [3:0] bitCount;
    logic [$clog2(uartTestPkg::ClocksPerBit)-1:0] bitTimer;
    logic busy;
    logic bitEnd;

    assign bitEnd  = (bitTimer == uartTestPkg::ClocksPerBit - 1);
    assign txEmpty = !busy;
    assign tx      = busy ? frame[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            bitTimer <= '0;
            bitCount <= '0;
        end else if (!busy) begin
            bitTimer <= '0;
            bitCount <= '0;
            if (txWrite) busy <= 1'b1;
        end else if (bitEnd) begin
            bitTimer <= '0;
            bitCount <= bitCount + 1'b1;
            if (bitCount == 4'd9) busy <= 1'b0;                // End of the stop bit.
        end else begin
            bitTimer <= bitTimer + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && txWrite) begin
            frame <= {1'b1, txData, 1'b0};
        end else if (busy && bitEnd) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

endmodule

//--- sim/uartMemoryTestTb.sv
`timescale 1ns/10ps
//////////////////////////////
// Testbench for the UART memory loopback tester.
// Sends 64 random bytes, rebuilds the echo
// and checks counts, order and the end level.
//////////////////////////////
module uartMemoryTestTb;
    localparam int ClockPeriod = 40;
    localparam int BitClocks   = uartTestPkg::ClocksPerBit;
    localparam int Capacity    = uartTestPkg::MemoryCapacity;
    localparam int LineSize    = uartTestPkg::LineSize;
    localparam int ExtraBytes  = 2;                             // Sent after the end level.
    // Receive pass plus echo pass, 10 bits per byte, with 20 percent margin.
    localparam int WatchdogTime = 2 * Capacity * 10 * BitClocks * ClockPeriod * 12 / 10;

    logic               clk;
    logic               rst;
    logic               uartRx;
    logic               uartTx;
    uartTestPkg::countT bytesReceived;
    logic               finished;

    int                 errorCount;
    int                 bytesSent;
    int                 echoCount;
    logic               echoDone;                               // All 64 frames seen on uartTx.
    logic [15:0]        lfsrState;
    uartTestPkg::countT lastCount;
    uartTestPkg::byteT  expected[$];

    uartMemoryTestUnit dut0 (.clk, .rst, .uartRx, .uartTx, .bytesReceived, .finished);

    always #(ClockPeriod / 2) clk = ~clk;

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic nextRandomByte(output uartTestPkg::byteT value);
        for (int i = 0; i < 8; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value[i]  = lfsrState[0];                           // One step per bit.
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] expectedValue,
                              input logic [31:0] actualValue);
        assert (actualValue === expectedValue) else begin
            errorCount++;
            $display("error at %0d ns: %s expected %0h got %0h",
                     $time, name, expectedValue, actualValue);
        end
    endtask

    // Called on a falling edge, returns on the falling edge that ends the bit.
    task automatic sendBit(input logic value);
        uartRx = value;
        repeat (BitClocks) @(negedge clk);
    endtask

    task automatic sendByte(input uartTestPkg::byteT value);
        sendBit(1'b0);
        for (int i = 0; i < 8; i++) sendBit(value[i]);          // LSB first.
        sendBit(1'b1);
    endtask

    // The line stays idle and finished stays low until the memory is full.
    assert property (@(posedge clk) disable iff (rst)
                     (bytesReceived != Capacity) |-> (uartTx && !finished))
    else begin
        errorCount++;
        $display("error at %0d ns: uartTx/finished expected 1/0 got %b/%b",
                 $time, uartTx, finished);
    end

    assert property (@(posedge clk) disable iff (rst) finished |=> finished)
    else begin
        errorCount++;
        $display("error at %0d ns: finished expected 1 got %b", $time, finished);
    end

    always @(negedge clk) begin
        if (rst) begin
            lastCount <= '0;
        end else begin
            if (bytesReceived != lastCount) begin
                checkValue("bytesReceived step", lastCount + LineSize, bytesReceived);
            end
            lastCount <= bytesReceived;
            if (echoDone) checkValue("uartTx after finish", 1, uartTx);
        end
    end

    // Serial monitor that samples uartTx at mid-bit.
    initial begin : serialMonitor
        uartTestPkg::byteT received;
        forever begin
            @(negedge clk);
            if (!rst && uartTx === 1'b0) begin
                checkValue("bytesReceived at start bit", Capacity, bytesReceived);
                // The last write to the transmitter also raises finished.
                checkValue("finished at start bit", echoCount == Capacity - 1, finished);
                repeat (BitClocks / 2) @(negedge clk);
                checkValue("uartTx start bit", 0, uartTx);
                for (int i = 0; i < 8; i++) begin
                    repeat (BitClocks) @(negedge clk);
                    received[i] = uartTx;
                end
                repeat (BitClocks) @(negedge clk);
                checkValue("uartTx stop bit", 1, uartTx);
                if (expected.size() == 0) begin
                    errorCount++;
                    $display("uartTx sent byte %0h at %0d ns with no byte left to echo",
                             received, $time);
                end else begin
                    checkValue("echoed byte", expected.pop_front(), received);
                end
                echoCount++;
                if (echoCount == Capacity) echoDone = 1'b1;
            end
        end
    end

    initial begin
        uartTestPkg::byteT value;
        clk        = 1'b0;
        rst        = 1'b1;
        uartRx     = 1'b1;
        errorCount = 0;
        bytesSent  = 0;
        echoCount  = 0;
        echoDone   = 1'b0;
        lfsrState  = 16'd2052;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) begin                                        // Idle values before the first byte.
            @(negedge clk);
            checkValue("uartTx", 1, uartTx);
            checkValue("finished", 0, finished);
            checkValue("bytesReceived", 0, bytesReceived);
        end
        for (int n = 1; n <= Capacity; n++) begin
            nextRandomByte(value);
            expected.push_back(value);
            sendByte(value);
            bytesSent++;
            checkValue("bytesReceived", (n / LineSize) * LineSize, bytesReceived);
        end
        wait (echoDone);
        @(negedge clk);
        checkValue("finished", 1, finished);
        for (int n = 0; n < ExtraBytes; n++) begin
            nextRandomByte(value);
            sendByte(value);
            bytesSent++;
            checkValue("bytesReceived", Capacity, bytesReceived);
        end
        repeat (10 * BitClocks) @(negedge clk);
        checkValue("echoed byte count", Capacity, echoCount);
        $display("errors %0d, bytes sent %0d, bytes echoed %0d", errorCount, bytesSent, echoCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin : watchdog
        #(WatchdogTime);
        $display("Watchdog expired: the echo of %0d bytes did not end in time", Capacity);
        $display("errors %0d, bytes sent %0d, bytes echoed %0d", errorCount, bytesSent, echoCount);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- tb.f
hw/uartTestPkg.sv
hw/uartReceiver.sv
hw/lineAssembler.sv
hw/lineMemory.sv
hw/uartTransmitter.sv
hw/memoryTestController.sv
hw/uartMemoryTestUnit.sv
sim/uartMemoryTestTb.sv
